// ==== hdl/sprite_params.svh ====
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

// Visible frame
`define SCREEN_COLS 256
`define SCREEN_LINES 240

// Sprite geometry
`define SPRITE_WIDTH 8
`define SPRITE_HEIGHT 8

// Primary and secondary object attribute memories
`define OAM_ENTRIES 64
`define SEC_OAM_ENTRIES 8

// Pattern memory depth in bytes
`define PAT_DEPTH 4096

// Pixel credits held by the unit after reset
`define PIX_CREDITS 4

`endif

// ==== hdl/sprite_pkg.sv ====
package sprite_pkg;

    // Row or column on the screen
    typedef logic [8:0] coord_t;

    // Byte address into primary OAM with 4 bytes per entry in the order y, tile, attribute, x
    typedef logic [7:0] oam_addr_t;

    typedef logic [11:0] pat_addr_t;
    typedef logic [7:0] byte_t;

    // {palette, colour}
    typedef logic [3:0] sp_color_t;

    typedef logic [2:0] credit_t;

    // Attribute bits 1..0 pick the palette, 5 is the priority, 6 and 7 flip across and down
    typedef struct packed {
        logic active;
        byte_t x_pos;
        byte_t attribute;
        byte_t bitmap_lo;
        byte_t bitmap_hi;
        byte_t tile;
        logic [2:0] prow;
    } second_oam_t;

    typedef enum logic [2:0] {
        IDLE,
        EVAL,
        FETCH,
        DRAW,
        LINE_END
    } line_state_t;

endpackage

// ==== hdl/dot_counter.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module dot_counter import sprite_pkg::*; (
    input logic clk,
    input logic rst,
    input logic clear_line,
    input logic step_col,
    // Bit 0 steps the index, bit 1 selects the short FETCH range
    input logic [1:0] step_idx,
    input logic next_line,
    input logic frame_start,
    output coord_t row,
    output coord_t col,
    output logic [5:0] idx,
    output logic last_col,
    output logic last_idx,
    output logic last_line
);

    assign last_col = (col == coord_t'(`SCREEN_COLS - 1));
    assign last_line = (row == coord_t'(`SCREEN_LINES - 1));
    assign last_idx = step_idx[1] ? (idx == 6'(2 * `SEC_OAM_ENTRIES - 1)) :
                                    (idx == 6'(`OAM_ENTRIES - 1));

    always_ff @(posedge clk) begin
        if (rst || frame_start) begin
            row <= '0;
            col <= '0;
            idx <= '0;
        end else begin
            if (clear_line) begin
                col <= '0;
                idx <= '0;
            end else begin
                if (step_col) begin
                    col <= last_col ? coord_t'(0) : col + coord_t'(1);
                end
                if (step_idx[0]) begin
                    idx <= last_idx ? 6'd0 : idx + 6'd1;
                end
            end
            if (next_line) begin
                row <= row + coord_t'(1);
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) col < coord_t'(`SCREEN_COLS));

endmodule

// ==== hdl/sprite_line_fsm.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module sprite_line_fsm import sprite_pkg::*; (
    input logic clk,
    input logic rst,
    input logic start_frame,
    input logic credit_return,
    input logic last_col,
    input logic last_idx,
    input logic last_line,
    output line_state_t state,
    output logic step_col,
    output logic [1:0] step_idx,
    output logic clear_line,
    output logic next_line,
    output logic frame_start,
    output logic frame_busy,
    output logic frame_done,
    output logic draw_fire
);

    line_state_t state_next;
    credit_t credits;
    logic frame_end;

    assign frame_end = (state == LINE_END) && last_line;

    always_comb begin
        state_next = state;
        step_col = 1'b0;
        step_idx = 2'b00;
        clear_line = 1'b0;
        next_line = 1'b0;
        frame_start = 1'b0;
        draw_fire = 1'b0;
        case (state)
            IDLE: begin
                if (start_frame) begin
                    frame_start = 1'b1;
                    state_next = EVAL;
                end
            end
            EVAL: begin
                step_idx = 2'b01;
                if (last_idx) state_next = FETCH;
            end
            FETCH: begin
                step_idx = 2'b11;
                if (last_idx) state_next = DRAW;
            end
            DRAW: begin
                // Column holds while the consumer owes us credits
                draw_fire = (credits != credit_t'(0));
                step_col = draw_fire;
                if (draw_fire && last_col) state_next = LINE_END;
            end
            LINE_END: begin
                clear_line = 1'b1;
                if (last_line) begin
                    state_next = IDLE;
                end else begin
                    next_line = 1'b1;
                    state_next = EVAL;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            credits <= credit_t'(`PIX_CREDITS);
            frame_busy <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            state <= state_next;
            credits <= credits + credit_t'(credit_return) - credit_t'(draw_fire);
            frame_done <= frame_end;
            if (frame_start) begin
                frame_busy <= 1'b1;
            end else if (frame_end) begin
                frame_busy <= 1'b0;
            end
        end
    end

    // Consumer may only return credits it actually holds
    assert property (@(posedge clk) disable iff (rst)
        credit_return && !draw_fire |-> credits < credit_t'(`PIX_CREDITS));

endmodule

// ==== hdl/sprite_eval.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module sprite_eval import sprite_pkg::*; (
    input logic clk,
    input logic rst,
    input logic oam_we,
    input oam_addr_t oam_addr,
    input byte_t oam_wdata,
    input logic eval_en,
    input logic [5:0] idx,
    input coord_t row,
    input logic frame_start,
    output second_oam_t sec_oam [`SEC_OAM_ENTRIES-1:0],
    output logic sprite_overflow
);

    byte_t oam_mem [0:4*`OAM_ENTRIES-1];

    byte_t spr_y;
    byte_t spr_tile;
    byte_t spr_attr;
    byte_t spr_x;
    coord_t row_diff;
    logic in_range;
    logic [2:0] prow;
    logic [3:0] slot_cnt;
    logic [3:0] slot;

    always_ff @(posedge clk) begin
        if (oam_we) begin
            oam_mem[oam_addr] <= oam_wdata;
        end
    end

    // All four bytes of the indexed entry at once
    assign spr_y = oam_mem[{idx, 2'd0}];
    assign spr_tile = oam_mem[{idx, 2'd1}];
    assign spr_attr = oam_mem[{idx, 2'd2}];
    assign spr_x = oam_mem[{idx, 2'd3}];

    // Rows above the sprite wrap to large values and fail the test
    assign row_diff = row - {1'b0, spr_y};
    assign in_range = row_diff < coord_t'(`SPRITE_HEIGHT);
    assign prow = spr_attr[7] ? 3'd7 - row_diff[2:0] : row_diff[2:0];

    // Slot count restarts with the first entry of each line
    assign slot = (idx == 6'd0) ? 4'd0 : slot_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= 4'd0;
            sprite_overflow <= 1'b0;
            for (int i = 0; i < `SEC_OAM_ENTRIES; i++) begin
                sec_oam[i].active <= 1'b0;
            end
        end else begin
            if (frame_start) begin
                sprite_overflow <= 1'b0;
            end
            if (eval_en) begin
                if (idx == 6'd0) begin
                    for (int i = 0; i < `SEC_OAM_ENTRIES; i++) begin
                        sec_oam[i].active <= 1'b0;
                    end
                end
                slot_cnt <= slot;
                if (in_range) begin
                    if (slot < 4'(`SEC_OAM_ENTRIES)) begin
                        sec_oam[slot[2:0]] <= '{
                            active: 1'b1,
                            x_pos: spr_x,
                            attribute: spr_attr,
                            bitmap_lo: 8'h00,
                            bitmap_hi: 8'h00,
                            tile: spr_tile,
                            prow: prow
                        };
                        slot_cnt <= slot + 4'd1;
                    end else begin
                        sprite_overflow <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/sprite_fetch.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module sprite_fetch import sprite_pkg::*; (
    input logic clk,
    input logic rst,
    input logic pat_we,
    input pat_addr_t pat_addr,
    input byte_t pat_wdata,
    input logic fetch_en,
    input logic [5:0] idx,
    input second_oam_t sec_oam_in [`SEC_OAM_ENTRIES-1:0],
    output second_oam_t sec_oam [`SEC_OAM_ENTRIES-1:0]
);

    byte_t pat_mem [0:`PAT_DEPTH-1];

    byte_t bitmap_lo [`SEC_OAM_ENTRIES-1:0];
    byte_t bitmap_hi [`SEC_OAM_ENTRIES-1:0];
    logic [`SEC_OAM_ENTRIES-1:0] loaded;
    logic [2:0] entry;
    logic plane;
    pat_addr_t rd_addr;

    always_ff @(posedge clk) begin
        if (pat_we) begin
            pat_mem[pat_addr] <= pat_wdata;
        end
    end

    // Two slots per entry with the low plane first
    assign entry = idx[3:1];
    assign plane = idx[0];

    // tile * 16 + plane * 8 + row
    assign rd_addr = {sec_oam_in[entry].tile, plane, sec_oam_in[entry].prow};

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            if (plane) begin
                bitmap_hi[entry] <= pat_mem[rd_addr];
            end else begin
                bitmap_lo[entry] <= pat_mem[rd_addr];
            end
        end
    end

    // An entry becomes visible once its high plane has landed
    always_ff @(posedge clk) begin
        if (rst) begin
            loaded <= '0;
        end else if (fetch_en) begin
            if (idx == 6'd0) begin
                loaded <= '0;
            end else if (plane) begin
                loaded[entry] <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SEC_OAM_ENTRIES; i++) begin
            sec_oam[i] = sec_oam_in[i];
            sec_oam[i].active = sec_oam_in[i].active & loaded[i];
            sec_oam[i].bitmap_lo = bitmap_lo[i];
            sec_oam[i].bitmap_hi = bitmap_hi[i];
        end
    end

endmodule

// ==== hdl/sp_pixel.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module sp_pixel import sprite_pkg::*; (
    input coord_t row,
    input coord_t col,
    input second_oam_t sec_oam [`SEC_OAM_ENTRIES-1:0],
    output sp_color_t sp_color_idx,
    output logic sp_prio
);

    sp_color_t colors [`SEC_OAM_ENTRIES-1:0];
    logic [`SEC_OAM_ENTRIES-1:0] prios;
    logic [`SEC_OAM_ENTRIES-1:0] hits;
    logic on_screen;

    genvar i;
    generate
        for (i = 0; i < `SEC_OAM_ENTRIES; i++) begin : g_sprite
            sp_pixel_h u_sp_pixel_h (
                .col(col),
                .sprite(sec_oam[i]),
                .sp_color_idx(colors[i]),
                .sp_prio(prios[i]),
                .hit(hits[i])
            );
        end
    endgenerate

    assign on_screen = (row < coord_t'(`SCREEN_LINES)) && (col < coord_t'(`SCREEN_COLS));

    // Walk from the top slot down so the lowest index wins
    always_comb begin
        sp_color_idx = '0;
        sp_prio = 1'b0;
        for (int s = `SEC_OAM_ENTRIES - 1; s >= 0; s--) begin
            if (on_screen && hits[s]) begin
                sp_color_idx = colors[s];
                sp_prio = prios[s];
            end
        end
    end

endmodule

module sp_pixel_h import sprite_pkg::*; (
    input coord_t col,
    input second_oam_t sprite,
    output sp_color_t sp_color_idx,
    output logic sp_prio,
    output logic hit
);

    coord_t col_within;
    logic [2:0] bit_idx;
    logic [1:0] color_idx;

    assign col_within = col - {1'b0, sprite.x_pos};

    // Bit 7 of each plane is the leftmost pixel unless flipped
    assign bit_idx = sprite.attribute[6] ? col_within[2:0] : 3'd7 - col_within[2:0];
    assign color_idx = {sprite.bitmap_hi[bit_idx], sprite.bitmap_lo[bit_idx]};

    assign sp_color_idx = {sprite.attribute[1:0], color_idx};
    assign sp_prio = sprite.attribute[5];

    // Colour 0 is transparent
    assign hit = sprite.active && (col_within < coord_t'(`SPRITE_WIDTH)) &&
                 (color_idx != 2'b00);

endmodule

// ==== hdl/sprite_unit_top.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module sprite_unit_top import sprite_pkg::*; (
    input logic clk,
    input logic rst,
    input logic oam_we,
    input oam_addr_t oam_addr,
    input byte_t oam_wdata,
    input logic pat_we,
    input pat_addr_t pat_addr,
    input byte_t pat_wdata,
    input logic start_frame,
    input logic credit_return,
    output logic pix_valid,
    output coord_t pix_row,
    output coord_t pix_col,
    output sp_color_t sp_color_idx,
    output logic sp_prio,
    output logic sprite_overflow,
    output logic frame_busy,
    output logic frame_done
);

    line_state_t state;
    logic step_col;
    logic [1:0] step_idx;
    logic clear_line;
    logic next_line;
    logic frame_start;
    logic draw_fire;
    logic last_col;
    logic last_idx;
    logic last_line;
    coord_t row;
    coord_t col;
    logic [5:0] idx;
    second_oam_t eval_sec [`SEC_OAM_ENTRIES-1:0];
    second_oam_t draw_sec [`SEC_OAM_ENTRIES-1:0];
    sp_color_t color_comb;
    logic prio_comb;

    sprite_line_fsm u_line_fsm (
        .clk(clk),
        .rst(rst),
        .start_frame(start_frame),
        .credit_return(credit_return),
        .last_col(last_col),
        .last_idx(last_idx),
        .last_line(last_line),
        .state(state),
        .step_col(step_col),
        .step_idx(step_idx),
        .clear_line(clear_line),
        .next_line(next_line),
        .frame_start(frame_start),
        .frame_busy(frame_busy),
        .frame_done(frame_done),
        .draw_fire(draw_fire)
    );

    dot_counter u_dot_counter (
        .clk(clk),
        .rst(rst),
        .clear_line(clear_line),
        .step_col(step_col),
        .step_idx(step_idx),
        .next_line(next_line),
        .frame_start(frame_start),
        .row(row),
        .col(col),
        .idx(idx),
        .last_col(last_col),
        .last_idx(last_idx),
        .last_line(last_line)
    );

    sprite_eval u_sprite_eval (
        .clk(clk),
        .rst(rst),
        .oam_we(oam_we),
        .oam_addr(oam_addr),
        .oam_wdata(oam_wdata),
        .eval_en(state == EVAL),
        .idx(idx),
        .row(row),
        .frame_start(frame_start),
        .sec_oam(eval_sec),
        .sprite_overflow(sprite_overflow)
    );

    sprite_fetch u_sprite_fetch (
        .clk(clk),
        .rst(rst),
        .pat_we(pat_we),
        .pat_addr(pat_addr),
        .pat_wdata(pat_wdata),
        .fetch_en(state == FETCH),
        .idx(idx),
        .sec_oam_in(eval_sec),
        .sec_oam(draw_sec)
    );

    sp_pixel u_sp_pixel (
        .row(row),
        .col(col),
        .sec_oam(draw_sec),
        .sp_color_idx(color_comb),
        .sp_prio(prio_comb)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= draw_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (draw_fire) begin
            pix_row <= row;
            pix_col <= col;
            sp_color_idx <= color_comb;
            sp_prio <= prio_comb;
        end
    end

    // OAM and patterns are frozen for the whole frame
    assert property (@(posedge clk) disable iff (rst) (oam_we || pat_we) |-> !frame_busy);

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== testbench/tb_sprite_unit.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module tb_sprite_unit import sprite_pkg::*; ();

    localparam int FRAMES = 2;
    localparam int LINE_CYCLES = 340;
    localparam int FRAME_PIXELS = `SCREEN_LINES * `SCREEN_COLS;
    // Random credit delays and hold windows, plus host loading before each frame
    localparam int STALL_CYCLES = FRAMES * FRAME_PIXELS * 2 + `PAT_DEPTH +
                                  FRAMES * 4 * `OAM_ENTRIES + 200;
    localparam int MAX_CYCLES = FRAMES * `SCREEN_LINES * LINE_CYCLES + STALL_CYCLES;

    logic clk;
    logic rst;
    logic oam_we;
    oam_addr_t oam_addr;
    byte_t oam_wdata;
    logic pat_we;
    pat_addr_t pat_addr;
    byte_t pat_wdata;
    logic start_frame;
    logic credit_return = 1'b0;
    logic pix_valid;
    coord_t pix_row;
    coord_t pix_col;
    sp_color_t sp_color_idx;
    logic sp_prio;
    logic sprite_overflow;
    logic frame_busy;
    logic frame_done;

    // Host-side copies of the DUT memories
    byte_t pat_model [0:`PAT_DEPTH-1];
    byte_t oam_model [0:4*`OAM_ENTRIES-1];
    byte_t oam_img0 [0:4*`OAM_ENTRIES-1];
    byte_t oam_img1 [0:4*`OAM_ENTRIES-1];

    int seed;
    int error_count = 0;
    int cycle_count = 0;
    int pix_taken = 0;
    int credits_back = 0;
    int frame_pixels = 0;
    int total_pixels = 0;
    int next_row = 0;
    int next_col = 0;
    int want_row = 0;
    int want_col = 0;
    logic withhold = 1'b0;
    logic order_ok = 1'b0;
    logic last_seen = 1'b0;
    logic exp_overflow = 1'b0;
    logic [4:0] expected = '0;

    tb_clock u_clock (
        .clk(clk)
    );

    sprite_unit_top u_dut (
        .clk(clk),
        .rst(rst),
        .oam_we(oam_we),
        .oam_addr(oam_addr),
        .oam_wdata(oam_wdata),
        .pat_we(pat_we),
        .pat_addr(pat_addr),
        .pat_wdata(pat_wdata),
        .start_frame(start_frame),
        .credit_return(credit_return),
        .pix_valid(pix_valid),
        .pix_row(pix_row),
        .pix_col(pix_col),
        .sp_color_idx(sp_color_idx),
        .sp_prio(sp_prio),
        .sprite_overflow(sprite_overflow),
        .frame_busy(frame_busy),
        .frame_done(frame_done)
    );

    task automatic log_failure(input string msg);
        error_count++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Returns {priority, palette, colour} for one screen position
    function automatic logic [4:0] model_pixel(input int r, input int c);
        int found;
        int dy;
        int dx;
        int prow;
        int bitn;
        int base;
        byte_t attr;
        byte_t lo;
        byte_t hi;
        logic [1:0] cidx;
        logic hit;
        logic [4:0] result;
        found = 0;
        hit = 1'b0;
        result = '0;
        for (int e = 0; e < `OAM_ENTRIES; e++) begin
            dy = r - int'(oam_model[4*e]);
            if (dy >= 0 && dy < `SPRITE_HEIGHT && found < `SEC_OAM_ENTRIES) begin
                found++;
                dx = c - int'(oam_model[4*e+3]);
                attr = oam_model[4*e+2];
                if (!hit && dx >= 0 && dx < `SPRITE_WIDTH) begin
                    prow = attr[7] ? 7 - dy : dy;
                    base = int'(oam_model[4*e+1]) * 16 + prow;
                    lo = pat_model[base];
                    hi = pat_model[base + 8];
                    bitn = attr[6] ? dx : 7 - dx;
                    cidx = {hi[bitn], lo[bitn]};
                    if (cidx != 2'b00) begin
                        hit = 1'b1;
                        result = {attr[5], attr[1:0], cidx};
                    end
                end
            end
        end
        return result;
    endfunction

    function automatic logic frame_overflows();
        int count;
        int dy;
        for (int r = 0; r < `SCREEN_LINES; r++) begin
            count = 0;
            for (int e = 0; e < `OAM_ENTRIES; e++) begin
                dy = r - int'(oam_model[4*e]);
                if (dy >= 0 && dy < `SPRITE_HEIGHT) count++;
            end
            if (count > `SEC_OAM_ENTRIES) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic build_oam_images();
        for (int b = 0; b < 4 * `OAM_ENTRIES; b++) begin
            oam_img0[b] = byte_t'($random(seed));
            oam_img1[b] = byte_t'($random(seed));
        end
        // Ten overlapping sprites on lines 120..123 force an overflow in frame 0
        for (int k = 0; k < 10; k++) begin
            oam_img0[4*(8+k)] = (k % 2 == 0) ? 8'd120 : 8'd116;
            oam_img0[4*(8+k)+3] = byte_t'(60 + 2 * k);
        end
        oam_img0[4*8+2] = 8'hC1;
        oam_img0[4*9+2] = 8'h62;
        // Frame 1 staggers y so no line holds more than two sprites
        for (int e = 0; e < `OAM_ENTRIES; e++) begin
            oam_img1[4*e] = byte_t'(4 * e);
        end
        oam_img1[3] = 8'd252;
    endtask

    task automatic load_patterns();
        for (int a = 0; a < `PAT_DEPTH; a++) begin
            @(negedge clk);
            pat_we = 1'b1;
            pat_addr = pat_addr_t'(a);
            pat_wdata = byte_t'($random(seed));
            pat_model[a] = pat_wdata;
        end
        @(negedge clk);
        pat_we = 1'b0;
    endtask

    task automatic load_oam(input int frame);
        for (int b = 0; b < 4 * `OAM_ENTRIES; b++) begin
            @(negedge clk);
            oam_we = 1'b1;
            oam_addr = oam_addr_t'(b);
            oam_wdata = (frame == 0) ? oam_img0[b] : oam_img1[b];
            oam_model[b] = oam_wdata;
        end
        @(negedge clk);
        oam_we = 1'b0;
    endtask

    task automatic run_frame();
        exp_overflow = frame_overflows();
        next_row = 0;
        next_col = 0;
        frame_pixels = 0;
        last_seen = 1'b0;
        @(negedge clk);
        start_frame = 1'b1;
        @(negedge clk);
        start_frame = 1'b0;
        while (!frame_done) @(negedge clk);
    endtask

    // Credit consumer that holds credits back for a short window every 2048 cycles
    always @(negedge clk) begin : consumer
        int r;
        cycle_count++;
        if (credit_return) credits_back++;
        if (pix_valid) pix_taken++;
        withhold = (cycle_count % 2048) < 40;
        credit_return = 1'b0;
        if (!rst && pix_taken > credits_back && !withhold) begin
            r = $random(seed);
            credit_return = (r[1:0] != 2'b00);
        end
    end

    always @(negedge clk) begin
        if (pix_valid) begin
            expected = model_pixel(int'(pix_row), int'(pix_col));
            want_row = next_row;
            want_col = next_col;
            order_ok = (int'(pix_row) == next_row) && (int'(pix_col) == next_col);
            last_seen = (int'(pix_row) == `SCREEN_LINES - 1) &&
                        (int'(pix_col) == `SCREEN_COLS - 1);
            frame_pixels++;
            total_pixels++;
            if (next_col == `SCREEN_COLS - 1) begin
                next_col = 0;
                next_row++;
            end else begin
                next_col++;
            end
        end
    end

    pixel_matches_model: assert property (@(posedge clk) disable iff (rst)
        pix_valid |-> {sp_prio, sp_color_idx} == expected)
        else log_failure($sformatf("pixel (%0d,%0d) got prio %b colour %h, expected %b %h",
            $sampled(pix_row), $sampled(pix_col), $sampled(sp_prio),
            $sampled(sp_color_idx), expected[4], expected[3:0]));

    pixel_in_order: assert property (@(posedge clk) disable iff (rst)
        pix_valid |-> order_ok)
        else log_failure($sformatf("pixel (%0d,%0d) out of order, expected (%0d,%0d)",
            $sampled(pix_row), $sampled(pix_col), want_row, want_col));

    done_after_last: assert property (@(posedge clk) disable iff (rst)
        frame_done |-> last_seen && frame_pixels == FRAME_PIXELS)
        else log_failure($sformatf("frame_done after %0d pixels", frame_pixels));

    overflow_at_done: assert property (@(posedge clk) disable iff (rst)
        frame_done |-> sprite_overflow == exp_overflow)
        else log_failure($sformatf("sprite_overflow %b, expected %b",
            $sampled(sprite_overflow), exp_overflow));

    credit_budget: assert property (@(posedge clk) disable iff (rst)
        pix_taken - credits_back <= `PIX_CREDITS)
        else log_failure($sformatf("%0d pixels outstanding with %0d credits",
            pix_taken - credits_back, `PIX_CREDITS));

    reset_values: assert property (@(posedge clk)
        $fell(rst) |-> !pix_valid && !frame_busy && !frame_done)
        else log_failure("outputs not idle after reset");

    busy_after_start: assert property (@(posedge clk) disable iff (rst)
        $past(start_frame) |-> frame_busy)
        else log_failure("frame_busy did not rise after start_frame");

    busy_until_done: assert property (@(posedge clk) disable iff (rst)
        $fell(frame_busy) |-> frame_done)
        else log_failure("frame_busy dropped without frame_done");

    pixel_while_busy: assert property (@(posedge clk) disable iff (rst)
        pix_valid |-> frame_busy)
        else log_failure("pix_valid outside a frame");

    initial begin : stimulus
        seed = 57924;
        rst = 1'b1;
        oam_we = 1'b0;
        oam_addr = '0;
        oam_wdata = '0;
        pat_we = 1'b0;
        pat_addr = '0;
        pat_wdata = '0;
        start_frame = 1'b0;
        build_oam_images();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        load_patterns();
        load_oam(0);
        run_frame();
        load_oam(1);
        run_frame();
        repeat (4) @(negedge clk);
        $display("Summary: %0d pixels checked, %0d errors", total_pixels, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < MAX_CYCLES) @(posedge clk);
        $display("Timeout: the frames did not finish within %0d cycles", MAX_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/sprite_pkg.sv
hdl/dot_counter.sv
hdl/sprite_line_fsm.sv
hdl/sprite_eval.sv
hdl/sprite_fetch.sv
hdl/sp_pixel.sv
hdl/sprite_unit_top.sv
testbench/tb_clock.sv
testbench/tb_sprite_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the testbench, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_sprite_unit -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
